//--- src/cpu_pkg.sv
`default_nettype none

package cpu_pkg;

    // datapath widths
    localparam int WORD_W = 32;
    localparam int REG_AW = 4;
    localparam int MEM_AW = 8;
    localparam int APB_AW = 12;

    typedef logic [WORD_W-1:0] word_t;
    typedef logic [REG_AW-1:0] reg_addr_t;
    typedef logic [MEM_AW-1:0] mem_addr_t;
    typedef logic [APB_AW-1:0] apb_addr_t;

    // instruction class, bits 31:29
    // 011, 101 and 110 only advance the pc
    typedef enum logic [2:0] {
        OP_ALU    = 3'b000,
        OP_MEM    = 3'b001,
        OP_BRANCH = 3'b010,
        OP_NOP3   = 3'b011,
        OP_MOVE   = 3'b100,
        OP_NOP5   = 3'b101,
        OP_NOP6   = 3'b110,
        OP_TERM   = 3'b111
    } opcode_e;

    // funct bits 2:0 of alu instructions
    typedef enum logic [2:0] {
        ALU_ADD = 3'b000,
        ALU_SUB = 3'b001,
        ALU_AND = 3'b010,
        ALU_OR  = 3'b011,
        ALU_XOR = 3'b100,
        ALU_SRL = 3'b101,
        ALU_SLL = 3'b110,
        ALU_SLT = 3'b111
    } alu_op_e;

    // branch condition, instruction bits 1:0
    typedef enum logic [1:0] {
        COND_ALWAYS = 2'b00,
        COND_NEG    = 2'b01,
        COND_POS    = 2'b10,
        COND_ZERO   = 2'b11
    } cond_e;

    // funct bit 4 picks the immediate form, bit 0 marks a store
    localparam int FUNCT_IMM_BIT   = 4;
    localparam int FUNCT_STORE_BIT = 0;

    typedef struct packed {
        opcode_e   opcode;
        reg_addr_t rs;
        reg_addr_t rt;
        reg_addr_t rd;
        logic [4:0] funct;
        word_t     imm;
    } decoded_t;

    typedef struct packed {
        logic      psel;
        logic      penable;
        logic      pwrite;
        apb_addr_t paddr;
        word_t     pwdata;
    } apb_req_t;

    typedef struct packed {
        word_t prdata;
        logic  pready;
        logic  pslverr;
    } apb_rsp_t;

    typedef struct packed {
        logic      en;
        logic      we;
        mem_addr_t addr;
        word_t     wdata;
    } mem_req_t;

    // host map, byte addresses, one word every 4 bytes
    localparam apb_addr_t IMEM_BASE = 12'h000;
    localparam apb_addr_t DMEM_BASE = 12'h400;
    localparam apb_addr_t CTRL_ADDR = 12'h800;
    localparam apb_addr_t REG_BASE  = 12'h840;

    // control write and status read bits
    localparam int CTRL_START_BIT = 0;
    localparam int STAT_RUN_BIT   = 0;
    localparam int STAT_DONE_BIT  = 1;

endpackage

`default_nettype wire

//--- src/reg_bank.sv
`timescale 1ns/1ps
`default_nettype none

module reg_bank
    import cpu_pkg::*;
(
    input  logic      clk,
    input  reg_addr_t rd_addr1,
    input  reg_addr_t rd_addr2,
    output word_t     rd_data1,
    output word_t     rd_data2,
    input  logic      wr_en,
    input  reg_addr_t wr_addr,
    input  word_t     wr_data
);

    // sixteen general registers, no r0 special case
    word_t regs [16];

    // single write port, cpu writeback only
    always_ff @(posedge clk)
    begin
        if (wr_en)
            regs[wr_addr] <= wr_data;
    end

    // reads are combinational
    // port 1 also serves host reads while stopped
    assign rd_data1 = regs[rd_addr1];
    assign rd_data2 = regs[rd_addr2];

endmodule

`default_nettype wire

//--- src/alu_unit.sv
`timescale 1ns/1ps
`default_nettype none

module alu_unit
    import cpu_pkg::*;
(
    input  logic    clk,
    input  word_t   op1,
    input  word_t   op2,
    input  alu_op_e alu_op,
    output word_t   result
);

    word_t res_next;

    always_comb
    begin
        case (alu_op)
            ALU_ADD: res_next = op1 + op2;
            ALU_SUB: res_next = op1 - op2;
            ALU_AND: res_next = op1 & op2;
            ALU_OR:  res_next = op1 | op2;
            ALU_XOR: res_next = op1 ^ op2;
            // shift amount from the low five bits only
            ALU_SRL: res_next = op1 >> op2[4:0];
            ALU_SLL: res_next = op1 << op2[4:0];
            // signed compare, result is 0 or 1
            ALU_SLT: res_next = {31'b0, $signed(op1) < $signed(op2)};
            default: res_next = '0;
        endcase
    end

    // result lands one cycle after execute
    always_ff @(posedge clk)
    begin
        result <= res_next;
    end

endmodule

`default_nettype wire

//--- src/branch_check.sv
`timescale 1ns/1ps
`default_nettype none

module branch_check
    import cpu_pkg::*;
(
    input  logic  clk,
    input  word_t test_value,
    input  cond_e cond,
    output logic  taken
);

    logic is_neg;
    logic is_zero;

    assign is_neg  = test_value[31];
    assign is_zero = (test_value == '0);

    // registered alongside the alu target
    always_ff @(posedge clk)
    begin
        case (cond)
            COND_ALWAYS: taken <= 1'b1;
            COND_NEG:    taken <= is_neg;
            // strictly greater than zero
            COND_POS:    taken <= !is_neg && !is_zero;
            default:     taken <= is_zero;
        endcase
    end

endmodule

`default_nettype wire

//--- src/word_mem.sv
`timescale 1ns/1ps
`default_nettype none

module word_mem
    import cpu_pkg::*;
#(
    parameter int DEPTH = 256
)
(
    input  logic     clk,
    input  mem_req_t req,
    output word_t    rdata
);

    word_t mem [DEPTH];

    // one port, read returns the old word on a write
    // rdata holds between accesses
    always_ff @(posedge clk)
    begin
        if (req.en)
        begin
            if (req.we)
                mem[req.addr] <= req.wdata;
            rdata <= mem[req.addr];
        end
    end

endmodule

`default_nettype wire

//--- src/cpu_control.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_control
    import cpu_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      start,
    output logic      running,
    output logic      done,
    output mem_req_t  imem_req,
    input  word_t     imem_rdata,
    output mem_req_t  dmem_req,
    input  word_t     dmem_rdata,
    input  reg_addr_t host_reg_addr,
    output reg_addr_t rd_addr1,
    output reg_addr_t rd_addr2,
    input  word_t     rd_data1,
    input  word_t     rd_data2,
    output logic      wr_en,
    output reg_addr_t wr_addr,
    output word_t     wr_data,
    output word_t     op1,
    output word_t     op2,
    output alu_op_e   alu_op,
    input  word_t     alu_result,
    output cond_e     cond,
    output word_t     test_value,
    input  logic      taken
);

    typedef enum logic [2:0] {
        S_FETCH,
        S_DECODE,
        S_EXECUTE,
        S_MEMORY,
        S_WRITEBACK
    } state_e;

    state_e   state;
    word_t    pc;
    word_t    npc;
    word_t    ir;
    decoded_t dec;

    logic is_alu;
    logic is_mem;
    logic is_branch;
    logic is_move;
    logic is_store;
    logic use_imm;

    // field split plus sign extension
    // branches take the 23-bit offset, everything else the 16-bit one
    function automatic decoded_t decode(input word_t instr);
        decoded_t d;
        d.opcode = opcode_e'(instr[31:29]);
        d.rs     = instr[28:25];
        d.rt     = instr[24:21];
        d.rd     = instr[20:17];
        d.funct  = instr[4:0];
        if (d.opcode == OP_BRANCH)
            d.imm = {{9{instr[24]}}, instr[24:2]};
        else
            d.imm = {{16{instr[20]}}, instr[20:5]};
        return d;
    endfunction

    // sequencer and pc
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state   <= S_FETCH;
            pc      <= '0;
            running <= 1'b0;
            done    <= 1'b0;
        end
        else if (start)
        begin
            state   <= S_FETCH;
            pc      <= '0;
            running <= 1'b1;
            done    <= 1'b0;
        end
        else if (running)
        begin
            case (state)
                S_FETCH:  state <= S_DECODE;
                S_DECODE: state <= S_EXECUTE;
                S_EXECUTE:
                begin
                    // terminate stops here, one cycle after decode
                    if (dec.opcode == OP_TERM)
                    begin
                        running <= 1'b0;
                        done    <= 1'b1;
                        state   <= S_FETCH;
                    end
                    else
                        state <= S_MEMORY;
                end
                S_MEMORY:
                begin
                    // alu holds pc + offset for branches
                    pc    <= (is_branch && taken) ? alu_result : npc;
                    state <= S_WRITEBACK;
                end
                default: state <= S_FETCH;
            endcase
        end
    end

    // instruction word arrives in decode
    always_ff @(posedge clk)
    begin
        if (running && state == S_FETCH)
            npc <= pc + 32'd1;
        if (running && state == S_DECODE)
        begin
            ir  <= imem_rdata;
            dec <= decode(imem_rdata);
        end
    end

    assign is_alu    = (dec.opcode == OP_ALU);
    assign is_mem    = (dec.opcode == OP_MEM);
    assign is_branch = (dec.opcode == OP_BRANCH);
    assign is_move   = (dec.opcode == OP_MOVE);
    assign is_store  = dec.funct[FUNCT_STORE_BIT];
    assign use_imm   = is_branch || is_mem || (is_alu && dec.funct[FUNCT_IMM_BIT]);

    // fetch
    always_comb
    begin
        imem_req       = '0;
        imem_req.en    = running && (state == S_FETCH);
        imem_req.addr  = pc[MEM_AW-1:0];
    end

    // host borrows read port 1 while stopped
    assign rd_addr1 = running ? dec.rs : host_reg_addr;
    assign rd_addr2 = dec.rt;

    // operand select, pc only for branch targets
    assign op1    = is_branch ? pc : rd_data1;
    assign op2    = use_imm ? dec.imm : rd_data2;
    assign alu_op = is_alu ? alu_op_e'(dec.funct[2:0]) : ALU_ADD;

    // branch condition straight from the instruction word
    assign cond       = cond_e'(ir[1:0]);
    assign test_value = rd_data1;

    // load or store at rs + offset, store data from rt
    always_comb
    begin
        dmem_req       = '0;
        dmem_req.en    = running && (state == S_MEMORY) && is_mem;
        dmem_req.we    = is_store;
        dmem_req.addr  = alu_result[MEM_AW-1:0];
        dmem_req.wdata = rd_data2;
    end

    // writeback
    // register-form alu writes rd, all others write rt
    assign wr_en   = running && (state == S_WRITEBACK) &&
                     (is_alu || is_move || (is_mem && !is_store));
    assign wr_addr = (is_alu && !dec.funct[FUNCT_IMM_BIT]) ? dec.rd : dec.rt;
    assign wr_data = is_mem ? dmem_rdata : (is_move ? rd_data1 : alu_result);

endmodule

`default_nettype wire

//--- src/apb_host_port.sv
`timescale 1ns/1ps
`default_nettype none

module apb_host_port
    import cpu_pkg::*;
#(
    parameter int IMEM_DEPTH = 256,
    parameter int DMEM_DEPTH = 256
)
(
    input  logic      clk,
    input  logic      rst,
    input  apb_req_t  apb_req,
    output apb_rsp_t  apb_rsp,
    input  logic      running,
    input  logic      done,
    output logic      start,
    input  mem_req_t  cpu_imem_req,
    input  mem_req_t  cpu_dmem_req,
    output mem_req_t  imem_req,
    output mem_req_t  dmem_req,
    input  word_t     imem_rdata,
    input  word_t     dmem_rdata,
    output reg_addr_t host_reg_addr,
    input  word_t     reg_rdata
);

    typedef enum logic [2:0] {
        RG_IMEM,
        RG_DMEM,
        RG_CTRL,
        RG_REGS,
        RG_NONE
    } region_e;

    region_e   region;
    mem_addr_t widx;
    mem_req_t  host_imem_req;
    mem_req_t  host_dmem_req;
    word_t     status;
    logic      access;
    logic      storage;
    logic      in_range;
    logic      refused;
    logic      host_en;
    logic      rd_wait;

    assign access        = apb_req.psel && apb_req.penable;
    assign widx          = apb_req.paddr[9:2];
    assign host_reg_addr = apb_req.paddr[5:2];

    // region decode
    always_comb
    begin
        region = RG_NONE;
        if (apb_req.paddr[11:10] == IMEM_BASE[11:10])
            region = RG_IMEM;
        else if (apb_req.paddr[11:10] == DMEM_BASE[11:10])
            region = RG_DMEM;
        else if (apb_req.paddr[11:6] == REG_BASE[11:6])
            region = RG_REGS;
        else if (apb_req.paddr[11:6] == CTRL_ADDR[11:6])
            region = RG_CTRL;
    end

    always_comb
    begin
        case (region)
            RG_IMEM: in_range = int'(widx) < IMEM_DEPTH;
            RG_DMEM: in_range = int'(widx) < DMEM_DEPTH;
            default: in_range = 1'b1;
        endcase
    end

    // memories and registers belong to the cpu during a run
    assign storage = (region == RG_IMEM) || (region == RG_DMEM) || (region == RG_REGS);
    assign refused = (region == RG_NONE) || (storage && (running || !in_range));

    // reads of storage get one wait state
    always_ff @(posedge clk)
    begin
        if (rst)
            rd_wait <= 1'b0;
        else
            rd_wait <= access && storage && !apb_req.pwrite && !refused && !rd_wait;
    end

    // access issued in the first access cycle only
    assign host_en = access && !rd_wait && !refused;

    always_comb
    begin
        host_imem_req       = '0;
        host_imem_req.en    = host_en && (region == RG_IMEM);
        host_imem_req.we    = apb_req.pwrite;
        host_imem_req.addr  = widx;
        host_imem_req.wdata = apb_req.pwdata;
        host_dmem_req       = host_imem_req;
        host_dmem_req.en    = host_en && (region == RG_DMEM);
    end

    // single point of arbitration
    assign imem_req = running ? cpu_imem_req : host_imem_req;
    assign dmem_req = running ? cpu_dmem_req : host_dmem_req;

    assign start = access && apb_req.pwrite && (region == RG_CTRL) &&
                   apb_req.pwdata[CTRL_START_BIT];

    always_comb
    begin
        status                = '0;
        status[STAT_RUN_BIT]  = running;
        status[STAT_DONE_BIT] = done;
    end

    always_comb
    begin
        apb_rsp         = '0;
        apb_rsp.pready  = access && (rd_wait || refused || apb_req.pwrite || !storage);
        apb_rsp.pslverr = access && refused;
        case (region)
            RG_IMEM: apb_rsp.prdata = imem_rdata;
            RG_DMEM: apb_rsp.prdata = dmem_rdata;
            RG_REGS: apb_rsp.prdata = reg_rdata;
            RG_CTRL: apb_rsp.prdata = status;
            default: apb_rsp.prdata = '0;
        endcase
    end

endmodule

`default_nettype wire

//--- src/cpu_top.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_top
    import cpu_pkg::*;
#(
    parameter int IMEM_DEPTH = 256,
    parameter int DMEM_DEPTH = 256
)
(
    input  logic     clk,
    input  logic     rst,
    input  apb_req_t apb_req,
    output apb_rsp_t apb_rsp
);

    // run control
    logic      running;
    logic      done;
    logic      start;

    // memory ports, cpu side and arbitrated side
    mem_req_t  cpu_imem_req;
    mem_req_t  cpu_dmem_req;
    mem_req_t  imem_req;
    mem_req_t  dmem_req;
    word_t     imem_rdata;
    word_t     dmem_rdata;

    // register file
    reg_addr_t host_reg_addr;
    reg_addr_t rd_addr1;
    reg_addr_t rd_addr2;
    word_t     rd_data1;
    word_t     rd_data2;
    logic      wr_en;
    reg_addr_t wr_addr;
    word_t     wr_data;

    // execute units
    word_t     op1;
    word_t     op2;
    alu_op_e   alu_op;
    word_t     alu_result;
    cond_e     cond;
    word_t     test_value;
    logic      taken;

    apb_host_port #(
        .IMEM_DEPTH(IMEM_DEPTH),
        .DMEM_DEPTH(DMEM_DEPTH)
    ) i_host (
        .clk(clk),
        .rst(rst),
        .apb_req(apb_req),
        .apb_rsp(apb_rsp),
        .running(running),
        .done(done),
        .start(start),
        .cpu_imem_req(cpu_imem_req),
        .cpu_dmem_req(cpu_dmem_req),
        .imem_req(imem_req),
        .dmem_req(dmem_req),
        .imem_rdata(imem_rdata),
        .dmem_rdata(dmem_rdata),
        .host_reg_addr(host_reg_addr),
        .reg_rdata(rd_data1)
    );

    cpu_control i_ctrl (
        .clk(clk),
        .rst(rst),
        .start(start),
        .running(running),
        .done(done),
        .imem_req(cpu_imem_req),
        .imem_rdata(imem_rdata),
        .dmem_req(cpu_dmem_req),
        .dmem_rdata(dmem_rdata),
        .host_reg_addr(host_reg_addr),
        .rd_addr1(rd_addr1),
        .rd_addr2(rd_addr2),
        .rd_data1(rd_data1),
        .rd_data2(rd_data2),
        .wr_en(wr_en),
        .wr_addr(wr_addr),
        .wr_data(wr_data),
        .op1(op1),
        .op2(op2),
        .alu_op(alu_op),
        .alu_result(alu_result),
        .cond(cond),
        .test_value(test_value),
        .taken(taken)
    );

    reg_bank i_regs (
        .clk(clk),
        .rd_addr1(rd_addr1),
        .rd_addr2(rd_addr2),
        .rd_data1(rd_data1),
        .rd_data2(rd_data2),
        .wr_en(wr_en),
        .wr_addr(wr_addr),
        .wr_data(wr_data)
    );

    alu_unit i_alu (
        .clk(clk),
        .op1(op1),
        .op2(op2),
        .alu_op(alu_op),
        .result(alu_result)
    );

    branch_check i_branch (
        .clk(clk),
        .test_value(test_value),
        .cond(cond),
        .taken(taken)
    );

    word_mem #(.DEPTH(IMEM_DEPTH)) i_imem (
        .clk(clk),
        .req(imem_req),
        .rdata(imem_rdata)
    );

    word_mem #(.DEPTH(DMEM_DEPTH)) i_dmem (
        .clk(clk),
        .req(dmem_req),
        .rdata(dmem_rdata)
    );

endmodule

`default_nettype wire

//--- test/tb_cpu.sv
`timescale 1ns/1ps
`default_nettype none

module tb_cpu
    import cpu_pkg::*;
();

    logic     clk;
    logic     rst;
    apb_req_t apb_req;
    apb_rsp_t apb_rsp;

    int seed;
    int errors;
    int checks;

    // model state, mirrors what the host put in the dut
    word_t prog [256];
    word_t exp_regs [16];
    word_t exp_dmem [256];
    word_t prog_q [$];

    cpu_top #(
        .IMEM_DEPTH(256),
        .DMEM_DEPTH(256)
    ) i_dut (
        .clk(clk),
        .rst(rst),
        .apb_req(apb_req),
        .apb_rsp(apb_rsp)
    );

    initial
    begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // instruction encoders
    function automatic word_t alu_reg_instr(input logic [2:0] op, input logic [3:0] rd,
                                            input logic [3:0] rs, input logic [3:0] rt);
        return {3'b000, rs, rt, rd, 12'b0, 2'b00, op};
    endfunction

    function automatic word_t alu_imm_instr(input logic [2:0] op, input logic [3:0] rt,
                                            input logic [3:0] rs, input logic [15:0] imm);
        return {3'b000, rs, rt, imm, 2'b10, op};
    endfunction

    function automatic word_t mem_instr(input logic store, input logic [3:0] rt,
                                        input logic [3:0] rs, input logic [15:0] imm);
        return {3'b001, rs, rt, imm, 4'b0000, store};
    endfunction

    function automatic word_t branch_instr(input logic [1:0] cond, input logic [3:0] rs,
                                           input logic [22:0] off);
        return {3'b010, rs, off, cond};
    endfunction

    function automatic word_t move_instr(input logic [3:0] rt, input logic [3:0] rs);
        return {3'b100, rs, rt, 21'b0};
    endfunction

    function automatic word_t term_instr();
        return {3'b111, 29'b0};
    endfunction

    // eight operations as the instruction set defines them
    function automatic word_t alu_model(input logic [2:0] op, input word_t a, input word_t b);
        case (op)
            3'd0: return a + b;
            3'd1: return a - b;
            3'd2: return a & b;
            3'd3: return a | b;
            3'd4: return a ^ b;
            3'd5: return a >> b[4:0];
            3'd6: return a << b[4:0];
            default: return {31'b0, $signed(a) < $signed(b)};
        endcase
    endfunction

    // instruction-set model, returns instructions before terminate
    function automatic int ref_run();
        logic [7:0] pc;
        int         count;
        word_t      w;
        word_t      imm16;
        word_t      imm23;
        word_t      b;
        word_t      t;
        logic       take;
        logic [3:0] rs;
        logic [3:0] rt;
        logic [3:0] rd;
        pc = 8'd0;
        count = 0;
        while (count < 100000)
        begin
            w = prog[pc];
            rs = w[28:25];
            rt = w[24:21];
            rd = w[20:17];
            imm16 = {{16{w[20]}}, w[20:5]};
            imm23 = {{9{w[24]}}, w[24:2]};
            if (w[31:29] == 3'b111)
                return count;
            count++;
            case (w[31:29])
                3'b000:
                begin
                    b = w[4] ? imm16 : exp_regs[rt];
                    t = alu_model(w[2:0], exp_regs[rs], b);
                    if (w[4])
                        exp_regs[rt] = t;
                    else
                        exp_regs[rd] = t;
                    pc = pc + 8'd1;
                end
                3'b001:
                begin
                    t = exp_regs[rs] + imm16;
                    if (w[0])
                        exp_dmem[t[7:0]] = exp_regs[rt];
                    else
                        exp_regs[rt] = exp_dmem[t[7:0]];
                    pc = pc + 8'd1;
                end
                3'b010:
                begin
                    t = exp_regs[rs];
                    case (w[1:0])
                        2'b00: take = 1'b1;
                        2'b01: take = t[31];
                        2'b10: take = !t[31] && (t != 0);
                        default: take = (t == 0);
                    endcase
                    pc = take ? pc + imm23[7:0] : pc + 8'd1;
                end
                3'b100:
                begin
                    exp_regs[rt] = exp_regs[rs];
                    pc = pc + 8'd1;
                end
                default: pc = pc + 8'd1;
            endcase
        end
        return count;
    endfunction

    task automatic check_word(input string name, input word_t exp, input word_t act);
        checks++;
        if (act !== exp)
        begin
            errors++;
            $display("error %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    // one apb transfer, waits for pready with a timeout
    task automatic apb_xfer(input logic wr, input apb_addr_t addr, input word_t wdata,
                            output word_t rdata, output logic err);
        int waited;
        @(posedge clk);
        #1;
        apb_req.psel    = 1'b1;
        apb_req.penable = 1'b0;
        apb_req.pwrite  = wr;
        apb_req.paddr   = addr;
        apb_req.pwdata  = wdata;
        @(posedge clk);
        #1;
        apb_req.penable = 1'b1;
        waited = 0;
        // sample away from the rising edge
        @(negedge clk);
        while (!apb_rsp.pready && waited < 16)
        begin
            @(negedge clk);
            waited++;
        end
        if (!apb_rsp.pready)
        begin
            errors++;
            $display("apb transfer at %h never got pready", addr);
        end
        rdata = apb_rsp.prdata;
        err   = apb_rsp.pslverr;
        @(posedge clk);
        #1;
        apb_req = '0;
    endtask

    task automatic host_write(input apb_addr_t addr, input word_t data);
        word_t rd;
        logic  err;
        apb_xfer(1'b1, addr, data, rd, err);
        if (err)
        begin
            errors++;
            $display("host write to %h was refused", addr);
        end
    endtask

    task automatic host_read(input apb_addr_t addr, output word_t data);
        logic err;
        apb_xfer(1'b0, addr, '0, data, err);
        if (err)
        begin
            errors++;
            $display("host read from %h was refused", addr);
        end
    endtask

    task automatic dmem_write(input int idx, input word_t data);
        host_write(DMEM_BASE + apb_addr_t'(4 * idx), data);
        exp_dmem[idx] = data;
    endtask

    task automatic load_program();
        foreach (prog_q[i])
        begin
            host_write(IMEM_BASE + apb_addr_t'(4 * i), prog_q[i]);
            prog[i] = prog_q[i];
        end
    endtask

    // registers and the low data words against the model
    task automatic compare_state(input string name);
        word_t rd;
        for (int r = 0; r < 16; r++)
        begin
            host_read(REG_BASE + apb_addr_t'(4 * r), rd);
            check_word({name, " reg"}, exp_regs[r], rd);
        end
        for (int i = 0; i < 64; i++)
        begin
            host_read(DMEM_BASE + apb_addr_t'(4 * i), rd);
            check_word({name, " dmem"}, exp_dmem[i], rd);
        end
    endtask

    // start, optionally poke the host port mid-run, wait for done
    task automatic run_program(input string name, input logic poke);
        int    n;
        int    cycles;
        word_t st;
        word_t rd;
        logic  err;
        n = ref_run();
        host_write(CTRL_ADDR, 32'h1);
        if (poke)
        begin
            apb_xfer(1'b0, CTRL_ADDR, '0, st, err);
            check_word({name, " status while running"}, 32'h1, st);
            apb_xfer(1'b1, DMEM_BASE + 12'h014, ~exp_dmem[5], rd, err);
            checks++;
            if (!err)
            begin
                errors++;
                $display("data memory write during a run was not refused");
            end
        end
        // rising edges counted from the one that completed the start write
        cycles = 0;
        @(negedge clk);
        while (!i_dut.done && cycles < 5 * n + 100)
        begin
            @(negedge clk);
            cycles++;
        end
        if (!i_dut.done)
        begin
            errors++;
            $display("%s run of %0d instructions never finished", name, n);
        end
        else if (!poke)
            check_word({name, " run cycles"}, word_t'(5 * n + 3), word_t'(cycles));
        apb_xfer(1'b0, CTRL_ADDR, '0, st, err);
        check_word({name, " status after run"}, 32'h2, st);
    endtask

    task automatic build_gcd();
        prog_q = {};
        prog_q.push_back(alu_imm_instr(3'd2, 4'd0, 4'd0, 16'h0000));
        prog_q.push_back(mem_instr(1'b0, 4'd1, 4'd0, 16'd60));
        prog_q.push_back(mem_instr(1'b0, 4'd2, 4'd0, 16'd61));
        // loop at 3
        prog_q.push_back(alu_reg_instr(3'd1, 4'd3, 4'd1, 4'd2));
        prog_q.push_back(branch_instr(2'b11, 4'd3, 23'd8));
        prog_q.push_back(branch_instr(2'b01, 4'd3, 23'd5));
        prog_q.push_back(branch_instr(2'b10, 4'd3, 23'd2));
        // only a missed positive branch ends up here
        prog_q.push_back(term_instr());
        prog_q.push_back(move_instr(4'd1, 4'd3));
        prog_q.push_back(branch_instr(2'b00, 4'd0, 23'h7ffffa));
        // a smaller than b
        prog_q.push_back(alu_reg_instr(3'd1, 4'd2, 4'd2, 4'd1));
        prog_q.push_back(branch_instr(2'b00, 4'd0, 23'h7ffff8));
        prog_q.push_back(mem_instr(1'b1, 4'd1, 4'd0, 16'd62));
        prog_q.push_back(term_instr());
    endtask

    initial
    begin
        word_t rd;
        seed    = 32'h8610d5e0;
        errors  = 0;
        checks  = 0;
        apb_req = '0;
        rst     = 1'b1;
        repeat (5) @(posedge clk);
        #1;
        rst = 1'b0;

        // host access to data memory while stopped
        host_read(CTRL_ADDR, rd);
        check_word("status after reset", 32'h0, rd);
        for (int i = 0; i < 64; i++)
            dmem_write(i, $random(seed));
        for (int i = 0; i < 64; i++)
        begin
            host_read(DMEM_BASE + apb_addr_t'(4 * i), rd);
            check_word("dmem readback", exp_dmem[i], rd);
        end

        // all eight operations, register and immediate form
        prog_q = {};
        prog_q.push_back(alu_imm_instr(3'd2, 4'd0, 4'd0, 16'h0000));
        prog_q.push_back(mem_instr(1'b0, 4'd1, 4'd0, 16'd0));
        prog_q.push_back(mem_instr(1'b0, 4'd2, 4'd0, 16'd1));
        for (int op = 0; op < 8; op++)
        begin
            prog_q.push_back(alu_reg_instr(3'(op), 4'd3, 4'd1, 4'd2));
            prog_q.push_back(mem_instr(1'b1, 4'd3, 4'd0, 16'(16 + op)));
            prog_q.push_back(alu_imm_instr(3'(op), 4'd4, 4'd1, 16'($random(seed))));
            prog_q.push_back(mem_instr(1'b1, 4'd4, 4'd0, 16'(24 + op)));
        end
        prog_q.push_back(term_instr());
        load_program();
        run_program("alu", 1'b0);
        compare_state("alu");

        // loads and stores around a base, moves between them
        prog_q = {};
        prog_q.push_back(alu_imm_instr(3'd2, 4'd0, 4'd0, 16'h0000));
        prog_q.push_back(alu_imm_instr(3'd0, 4'd5, 4'd0, 16'd40));
        prog_q.push_back(mem_instr(1'b0, 4'd6, 4'd5, 16'hffda));
        prog_q.push_back(mem_instr(1'b0, 4'd7, 4'd5, 16'd3));
        prog_q.push_back(move_instr(4'd8, 4'd6));
        prog_q.push_back(move_instr(4'd9, 4'd7));
        prog_q.push_back(mem_instr(1'b1, 4'd8, 4'd5, 16'hffe2));
        prog_q.push_back(mem_instr(1'b1, 4'd9, 4'd5, 16'd10));
        prog_q.push_back(move_instr(4'd10, 4'd5));
        prog_q.push_back(term_instr());
        load_program();
        run_program("mem", 1'b0);
        compare_state("mem");

        // gcd by subtraction with random pairs
        build_gcd();
        load_program();
        for (int k = 0; k < 3; k++)
        begin
            dmem_write(60, word_t'({$random(seed)} % 200 + 1));
            dmem_write(61, word_t'({$random(seed)} % 200 + 1));
            run_program("gcd", 1'b0);
            compare_state("gcd");
        end

        // restart after done, refused access during a long run
        dmem_write(60, 32'd200);
        dmem_write(61, 32'd3);
        run_program("restart", 1'b1);
        compare_state("restart");

        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0)
            $display("TEST OK");
        else
            $display("TEST FAILED");
        $finish;
    end

endmodule

`default_nettype wire

//--- build.f
src/cpu_pkg.sv
src/reg_bank.sv
src/alu_unit.sv
src/branch_check.sv
src/word_mem.sv
src/cpu_control.sv
src/apb_host_port.sv
src/cpu_top.sv
test/tb_cpu.sv

//--- Makefile
TOP = tb_cpu

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --top-module $(TOP) -f build.f

sim:
	verilator --binary --timing --top-module $(TOP) -f build.f -o tb_sim
	./obj_dir/tb_sim | tee /dev/stderr | grep -qx "TEST OK"

clean:
	rm -rf obj_dir
